// ==== compile.f ====
logic/mem_test_pkg.sv
logic/reg_slice.sv
logic/scratch_mem.sv
logic/mem_arbiter.sv
logic/rdwr_engine.sv
logic/csr_mgr.sv
logic/mem_test_top.sv
sim/tb_mem_test.sv

// ==== logic/csr_mgr.sv ====
// MMIO CSR manager
`timescale 1ns/1ns

module csr_mgr
(
    input  logic clk,
    input  logic reset,

    input  mem_test_pkg::t_mmio_req mmio_req,
    output mem_test_pkg::t_mmio_rsp mmio_rsp,

    output logic [mem_test_pkg::NUM_ENGINES-1:0] cmd_valid,
    input  logic [mem_test_pkg::NUM_ENGINES-1:0] cmd_ready,
    output mem_test_pkg::t_eng_cmd cmd [mem_test_pkg::NUM_ENGINES],

    input  mem_test_pkg::t_eng_status eng_status [mem_test_pkg::NUM_ENGINES]
);

    logic in_eng_space;
    logic [mem_test_pkg::MMIO_ADDR_W-1:0] slot;
    logic [mem_test_pkg::MMIO_ADDR_W-1:0] slot_eng;
    logic [mem_test_pkg::MMIO_ADDR_W-1:0] slot_ofs;
    logic [mem_test_pkg::DATA_W-1:0] rd_data;
    mem_test_pkg::t_eng_cmd cfg [mem_test_pkg::NUM_ENGINES];

    // ============================================================
    // Address decode
    // ============================================================

    // Engine slots follow the globals, one stride per engine
    assign in_eng_space = (mmio_req.address >= mem_test_pkg::ENG_CSR_BASE) &&
                          (int'(mmio_req.address) < int'(mem_test_pkg::ENG_CSR_BASE) +
                           mem_test_pkg::NUM_ENGINES * int'(mem_test_pkg::ENG_CSR_STRIDE));
    assign slot = mmio_req.address - mem_test_pkg::ENG_CSR_BASE;
    assign slot_eng = slot / mem_test_pkg::ENG_CSR_STRIDE;
    assign slot_ofs = slot % mem_test_pkg::ENG_CSR_STRIDE;

    // Per-engine base, count and seed registers
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
            begin
                cfg[e] <= '0;
            end
        end
        else if (mmio_req.write && in_eng_space)
        begin
            for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
            begin
                if (slot_eng == mem_test_pkg::MMIO_ADDR_W'(e))
                begin
                    case (slot_ofs)
                        mem_test_pkg::OFS_BASE:
                            cfg[e].base <= mmio_req.writedata[mem_test_pkg::ADDR_W-1:0];
                        mem_test_pkg::OFS_COUNT:
                            cfg[e].count <= mmio_req.writedata[mem_test_pkg::COUNT_W-1:0];
                        mem_test_pkg::OFS_SEED:
                            cfg[e].seed <= mmio_req.writedata;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ============================================================
    // Start command queues
    // ============================================================

    for (genvar e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
    begin : eng
        logic start;

        // Bit 0 of a control write launches the current configuration
        assign start = mmio_req.write && in_eng_space &&
                       (slot_eng == mem_test_pkg::MMIO_ADDR_W'(e)) &&
                       (slot_ofs == mem_test_pkg::OFS_CTRL) && mmio_req.writedata[0];

        // One waiting start per engine; a start into a full queue is lost
        reg_slice #(.t_payload(mem_test_pkg::t_eng_cmd)) cmd_q
        (
            .clk,
            .reset,
            .in_valid(start),
            .in_ready(),
            .in_data(cfg[e]),
            .out_valid(cmd_valid[e]),
            .out_ready(cmd_ready[e]),
            .out_data(cmd[e])
        );
    end

    // ============================================================
    // Read path
    // ============================================================

    always_comb
    begin
        case (mmio_req.address)
            mem_test_pkg::CSR_ID_LO: rd_data = mem_test_pkg::TEST_ID[63:0];
            mem_test_pkg::CSR_ID_HI: rd_data = mem_test_pkg::TEST_ID[127:64];
            mem_test_pkg::CSR_INFO:
                rd_data = mem_test_pkg::DATA_W'(8'(mem_test_pkg::NUM_ENGINES));
            default: rd_data = '0;
        endcase

        if (in_eng_space)
        begin
            for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
            begin
                if (slot_eng == mem_test_pkg::MMIO_ADDR_W'(e))
                begin
                    case (slot_ofs)
                        mem_test_pkg::OFS_BASE:
                            rd_data = mem_test_pkg::DATA_W'(cfg[e].base);
                        mem_test_pkg::OFS_COUNT:
                            rd_data = mem_test_pkg::DATA_W'(cfg[e].count);
                        mem_test_pkg::OFS_SEED:
                            rd_data = cfg[e].seed;
                        // A queued start already counts as busy
                        mem_test_pkg::OFS_CTRL:
                            rd_data = mem_test_pkg::DATA_W'({eng_status[e].busy || cmd_valid[e],
                                                              eng_status[e].done});
                        mem_test_pkg::OFS_SUM:
                            rd_data = eng_status[e].checksum;
                        default: rd_data = '0;
                    endcase
                end
            end
        end
    end

    // Read data answers one cycle after the request
    always_ff @(posedge clk)
    begin
        mmio_rsp.readdata <= rd_data;
        if (reset)
        begin
            mmio_rsp.valid <= 1'b0;
        end
        else
        begin
            mmio_rsp.valid <= mmio_req.read;
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
// Round-robin memory arbiter
`timescale 1ns/1ns

module mem_arbiter
(
    input  logic clk,
    input  logic reset,

    input  logic [mem_test_pkg::NUM_ENGINES-1:0] eng_req_valid,
    output logic [mem_test_pkg::NUM_ENGINES-1:0] eng_req_ready,
    input  mem_test_pkg::t_mem_req eng_req [mem_test_pkg::NUM_ENGINES],

    output logic mem_req_valid,
    output mem_test_pkg::t_mem_req mem_req,

    input  logic mem_rsp_valid,
    input  mem_test_pkg::t_mem_rsp mem_rsp,

    output logic [mem_test_pkg::NUM_ENGINES-1:0] eng_rsp_valid,
    output mem_test_pkg::t_mem_rsp eng_rsp [mem_test_pkg::NUM_ENGINES]
);

    logic [mem_test_pkg::ENG_ID_W-1:0] last;
    logic [mem_test_pkg::ENG_ID_W-1:0] pick;
    logic found;

    // Search starts one past the previous winner and wraps around
    always_comb
    begin
        found = 1'b0;
        pick = last;
        for (int i = 1; i <= mem_test_pkg::NUM_ENGINES; i++)
        begin
            if (!found && eng_req_valid[(int'(last) + i) % mem_test_pkg::NUM_ENGINES])
            begin
                found = 1'b1;
                pick = mem_test_pkg::ENG_ID_W'((int'(last) + i) % mem_test_pkg::NUM_ENGINES);
            end
        end

        eng_req_ready = '0;
        if (found)
        begin
            eng_req_ready[pick] = 1'b1;
        end
    end

    // Memory never stalls, so the winner goes straight through
    assign mem_req_valid = found;
    assign mem_req = eng_req[pick];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last <= '0;
        end
        else if (found)
        begin
            last <= pick;
        end
    end

    // Responses are steered by the id they carry
    always_comb
    begin
        for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
        begin
            eng_rsp_valid[e] = mem_rsp_valid && (mem_rsp.id == mem_test_pkg::ENG_ID_W'(e));
            eng_rsp[e] = mem_rsp;
        end
    end

endmodule

// ==== logic/mem_test_pkg.sv ====
// Memory test shared definitions

package mem_test_pkg;

    // ============================================================
    // Sizes
    // ============================================================

    localparam int NUM_ENGINES = 4;
    localparam int ENG_ID_W = 2;
    // Word address into the 1024-word scratch memory
    localparam int ADDR_W = 10;
    localparam int DATA_W = 64;
    localparam int COUNT_W = 16;
    localparam int MMIO_ADDR_W = 6;

    // Identifies this test to software
    localparam logic [127:0] TEST_ID = 128'h7a3e91c2_5d04_4f6b_b8e1_2c9f03d6a5e7;

    // ============================================================
    // CSR map (64-bit word addresses)
    // ============================================================

    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_LO = 6'd0;
    localparam logic [MMIO_ADDR_W-1:0] CSR_ID_HI = 6'd1;
    localparam logic [MMIO_ADDR_W-1:0] CSR_INFO = 6'd2;

    // Engine e owns the slot starting at ENG_CSR_BASE + e * ENG_CSR_STRIDE
    localparam logic [MMIO_ADDR_W-1:0] ENG_CSR_BASE = 6'd8;
    localparam logic [MMIO_ADDR_W-1:0] ENG_CSR_STRIDE = 6'd8;

    localparam logic [MMIO_ADDR_W-1:0] OFS_BASE = 6'd0;
    localparam logic [MMIO_ADDR_W-1:0] OFS_COUNT = 6'd1;
    localparam logic [MMIO_ADDR_W-1:0] OFS_SEED = 6'd2;
    localparam logic [MMIO_ADDR_W-1:0] OFS_CTRL = 6'd3;
    localparam logic [MMIO_ADDR_W-1:0] OFS_SUM = 6'd4;

    // ============================================================
    // Bundles
    // ============================================================

    typedef struct packed {
        logic read;
        logic write;
        logic [MMIO_ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
    } t_mmio_req;

    typedef struct packed {
        logic valid;
        logic [DATA_W-1:0] readdata;
    } t_mmio_rsp;

    // One start command for an engine
    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [COUNT_W-1:0] count;
        logic [DATA_W-1:0] seed;
    } t_eng_cmd;

    typedef struct packed {
        logic busy;
        logic done;
        logic [DATA_W-1:0] checksum;
    } t_eng_status;

    typedef struct packed {
        logic [ENG_ID_W-1:0] id;
        logic write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } t_mem_req;

    typedef struct packed {
        logic [ENG_ID_W-1:0] id;
        logic [DATA_W-1:0] data;
    } t_mem_rsp;

endpackage

// ==== logic/mem_test_top.sv ====
// Memory exerciser top level
`timescale 1ns/1ns

module mem_test_top
(
    input  logic clk,
    input  logic reset,

    input  mem_test_pkg::t_mmio_req mmio_req,
    output mem_test_pkg::t_mmio_rsp mmio_rsp
);

    logic [mem_test_pkg::NUM_ENGINES-1:0] cmd_valid;
    logic [mem_test_pkg::NUM_ENGINES-1:0] cmd_ready;
    mem_test_pkg::t_eng_cmd cmd [mem_test_pkg::NUM_ENGINES];
    mem_test_pkg::t_eng_status eng_status [mem_test_pkg::NUM_ENGINES];

    logic [mem_test_pkg::NUM_ENGINES-1:0] eng_req_valid;
    logic [mem_test_pkg::NUM_ENGINES-1:0] eng_req_ready;
    mem_test_pkg::t_mem_req eng_req [mem_test_pkg::NUM_ENGINES];
    logic [mem_test_pkg::NUM_ENGINES-1:0] eng_rsp_valid;
    mem_test_pkg::t_mem_rsp eng_rsp [mem_test_pkg::NUM_ENGINES];

    logic mem_req_valid;
    mem_test_pkg::t_mem_req mem_req;
    logic mem_rsp_valid;
    mem_test_pkg::t_mem_rsp mem_rsp;

    // ============================================================
    // Control
    // ============================================================

    csr_mgr csr_mgr
    (
        .clk,
        .reset,
        .mmio_req,
        .mmio_rsp,
        .cmd_valid,
        .cmd_ready,
        .cmd,
        .eng_status
    );

    // ============================================================
    // Engines and the shared memory port
    // ============================================================

    for (genvar e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
    begin : eng
        rdwr_engine #(.ENGINE_ID(e)) engine
        (
            .clk,
            .reset,
            .cmd_valid(cmd_valid[e]),
            .cmd_ready(cmd_ready[e]),
            .cmd(cmd[e]),
            .req_valid(eng_req_valid[e]),
            .req_ready(eng_req_ready[e]),
            .req(eng_req[e]),
            .rsp_valid(eng_rsp_valid[e]),
            .rsp(eng_rsp[e]),
            .status(eng_status[e])
        );
    end

    mem_arbiter arbiter
    (
        .clk,
        .reset,
        .eng_req_valid,
        .eng_req_ready,
        .eng_req,
        .mem_req_valid,
        .mem_req,
        .mem_rsp_valid,
        .mem_rsp,
        .eng_rsp_valid,
        .eng_rsp
    );

    scratch_mem memory
    (
        .clk,
        .reset,
        .req_valid(mem_req_valid),
        .req(mem_req),
        .rsp_valid(mem_rsp_valid),
        .rsp(mem_rsp)
    );

endmodule

// ==== logic/rdwr_engine.sv ====
// Write then read-back engine
`timescale 1ns/1ns

module rdwr_engine
#(
    parameter int ENGINE_ID = 0
)
(
    input  logic clk,
    input  logic reset,

    input  logic cmd_valid,
    output logic cmd_ready,
    input  mem_test_pkg::t_eng_cmd cmd,

    output logic req_valid,
    input  logic req_ready,
    output mem_test_pkg::t_mem_req req,

    input  logic rsp_valid,
    input  mem_test_pkg::t_mem_rsp rsp,

    output mem_test_pkg::t_eng_status status
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_READ
    } t_state;

    t_state state;
    mem_test_pkg::t_eng_cmd cur;
    logic [mem_test_pkg::COUNT_W-1:0] issue_cnt;
    logic [mem_test_pkg::COUNT_W-1:0] rsp_cnt;
    logic [mem_test_pkg::DATA_W-1:0] checksum;
    logic done;
    logic start;
    logic issue_valid;
    logic issue_ready;
    logic issue_fire;
    logic rsp_hit;
    mem_test_pkg::t_mem_req issue_req;

    // New work is taken only between runs
    assign cmd_ready = (state == S_IDLE);
    assign start = cmd_valid && cmd_ready;

    // Reads stop issuing once all N are out, then the FSM waits for returns
    assign issue_valid = (state == S_WRITE) ||
                         ((state == S_READ) && (issue_cnt != cur.count));
    assign issue_fire = issue_valid && issue_ready;

    // Only count responses carrying this engine's id
    assign rsp_hit = rsp_valid && (rsp.id == mem_test_pkg::ENG_ID_W'(ENGINE_ID));

    // Word i lives at base + i and holds seed + i
    always_comb
    begin
        issue_req.id = mem_test_pkg::ENG_ID_W'(ENGINE_ID);
        issue_req.write = (state == S_WRITE);
        issue_req.addr = cur.base + issue_cnt[mem_test_pkg::ADDR_W-1:0];
        issue_req.data = cur.seed + mem_test_pkg::DATA_W'(issue_cnt);
    end

    // The address counter only advances on an accepted request, so a
    // stalled request keeps its payload
    reg_slice #(.t_payload(mem_test_pkg::t_mem_req)) req_q
    (
        .clk,
        .reset,
        .in_valid(issue_valid),
        .in_ready(issue_ready),
        .in_data(issue_req),
        .out_valid(req_valid),
        .out_ready(req_ready),
        .out_data(req)
    );

    // Captured command for the active run
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cur <= cmd;
        end
    end

    // ============================================================
    // Run control
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            issue_cnt <= '0;
            rsp_cnt <= '0;
            checksum <= '0;
            done <= 1'b0;
        end
        else if (start)
        begin
            issue_cnt <= '0;
            rsp_cnt <= '0;
            checksum <= '0;
            // An empty run completes at once with a zero checksum
            done <= (cmd.count == '0);
            state <= (cmd.count == '0) ? S_IDLE : S_WRITE;
        end
        else
        begin
            if (issue_fire)
            begin
                if ((state == S_WRITE) &&
                    (issue_cnt == cur.count - mem_test_pkg::COUNT_W'(1)))
                begin
                    issue_cnt <= '0;
                    state <= S_READ;
                end
                else
                begin
                    issue_cnt <= issue_cnt + mem_test_pkg::COUNT_W'(1);
                end
            end

            // Many reads may be in flight, each return is summed as it lands
            if (rsp_hit)
            begin
                checksum <= checksum + rsp.data;
                rsp_cnt <= rsp_cnt + mem_test_pkg::COUNT_W'(1);
                if (rsp_cnt == cur.count - mem_test_pkg::COUNT_W'(1))
                begin
                    state <= S_IDLE;
                    done <= 1'b1;
                end
            end
        end
    end

    assign status = '{busy: (state != S_IDLE), done: done, checksum: checksum};

endmodule

// ==== logic/reg_slice.sv ====
// Valid/ready register slice
`timescale 1ns/1ns

module reg_slice
#(
    parameter type t_payload = logic
)
(
    input  logic clk,
    input  logic reset,

    input  logic in_valid,
    output logic in_ready,
    input  t_payload in_data,

    output logic out_valid,
    input  logic out_ready,
    output t_payload out_data
);

    // Room exists when the slot is empty or its entry leaves this cycle,
    // so back-to-back transfers run at one per cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_data <= in_data;
        end
    end

endmodule

// ==== logic/scratch_mem.sv ====
// Scratch word memory
`timescale 1ns/1ns

module scratch_mem
(
    input  logic clk,
    input  logic reset,

    input  logic req_valid,
    input  mem_test_pkg::t_mem_req req,

    output logic rsp_valid,
    output mem_test_pkg::t_mem_rsp rsp
);

    logic [mem_test_pkg::DATA_W-1:0] mem [1 << mem_test_pkg::ADDR_W];

    always_ff @(posedge clk)
    begin
        if (req_valid && req.write)
        begin
            mem[req.addr] <= req.data;
        end
    end

    // Read data and the requester id come back on the next cycle
    always_ff @(posedge clk)
    begin
        if (req_valid && !req.write)
        begin
            rsp.data <= mem[req.addr];
            rsp.id <= req.id;
        end

        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= req_valid && !req.write;
        end
    end

endmodule

// ==== sim/tb_mem_test.sv ====
// Memory exerciser testbench
`timescale 1ns/1ns

module tb_mem_test;

    logic clk;
    logic reset;
    mem_test_pkg::t_mmio_req mmio_req;
    mem_test_pkg::t_mmio_rsp mmio_rsp;

    // Free-running cycle count used by the engine poll timeout
    int unsigned cycle_count;
    logic [31:0] lfsr_state;

    // Pending comparisons, filled by the sequence and drained by the checker
    logic [63:0] got_q [$];
    logic [63:0] exp_q [$];
    string what_q [$];

    mem_test_top UUT
    (
        .clk,
        .reset,
        .mmio_req,
        .mmio_rsp
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    // ============================================================
    // Reporting and checking
    // ============================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        if (got !== expected)
        begin
            abort_run($sformatf("error: time %0t ns: %s: got %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    task automatic expect_value(input logic [63:0] got, input logic [63:0] expected,
                                input string what);
        got_q.push_back(got);
        exp_q.push_back(expected);
        what_q.push_back(what);
    endtask

    // Compares one queued result per clock
    always @(posedge clk)
    begin : compare_proc
        logic [63:0] got;
        logic [63:0] expected;
        string what;
        if (got_q.size() != 0)
        begin
            got = got_q.pop_front();
            expected = exp_q.pop_front();
            what = what_q.pop_front();
            check_equal(got, expected, what);
        end
    end

    // ============================================================
    // Reference model and random numbers
    // ============================================================

    // Writes word i = seed + i at base + i, then sums the same addresses back
    function automatic logic [63:0] ref_checksum(input logic [9:0] base, input int n,
                                                 input logic [63:0] seed);
        logic [63:0] words [1024];
        logic [63:0] sum;
        sum = '0;
        for (int i = 0; i < n; i++)
        begin
            words[(int'(base) + i) % 1024] = seed + 64'(i);
        end
        for (int i = 0; i < n; i++)
        begin
            sum = sum + words[(int'(base) + i) % 1024];
        end
        return sum;
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
    endtask

    // ============================================================
    // MMIO access
    // ============================================================

    function automatic logic [5:0] eng_addr(input int e, input logic [5:0] ofs);
        return mem_test_pkg::ENG_CSR_BASE + 6'(e) * mem_test_pkg::ENG_CSR_STRIDE + ofs;
    endfunction

    task automatic mmio_write(input logic [5:0] addr, input logic [63:0] data);
        @(posedge clk);
        #1;
        mmio_req.write = 1'b1;
        mmio_req.address = addr;
        mmio_req.writedata = data;
        @(posedge clk);
        #1;
        mmio_req.write = 1'b0;
    endtask

    task automatic mmio_read(input logic [5:0] addr, output logic [63:0] data);
        int waited;
        @(posedge clk);
        #1;
        mmio_req.read = 1'b1;
        mmio_req.address = addr;
        @(posedge clk);
        #1;
        mmio_req.read = 1'b0;
        waited = 0;
        while (!mmio_rsp.valid)
        begin
            if (waited >= 4)
                abort_run($sformatf("MMIO read of address %0d got no response in 4 cycles",
                                    addr));
            else
            begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        // Read data is due exactly one cycle after the read request
        check_equal(64'(waited), 64'd0, "MMIO read latency");
        data = mmio_rsp.readdata;
    endtask

    task automatic configure_engine(input int e, input logic [9:0] base,
                                    input logic [15:0] count, input logic [63:0] seed);
        mmio_write(eng_addr(e, mem_test_pkg::OFS_BASE), 64'(base));
        mmio_write(eng_addr(e, mem_test_pkg::OFS_COUNT), 64'(count));
        mmio_write(eng_addr(e, mem_test_pkg::OFS_SEED), seed);
    endtask

    task automatic start_engine(input int e);
        mmio_write(eng_addr(e, mem_test_pkg::OFS_CTRL), 64'd1);
    endtask

    // Polls the control word until done is set and nothing is queued or running
    task automatic wait_engine(input int e);
        logic [63:0] ctrl;
        int unsigned start_cycle;
        start_cycle = cycle_count;
        mmio_read(eng_addr(e, mem_test_pkg::OFS_CTRL), ctrl);
        while (!(ctrl[0] && !ctrl[1]))
        begin
            if (cycle_count - start_cycle >= 5000)
                abort_run($sformatf("engine %0d did not finish within 5000 cycles", e));
            else
                mmio_read(eng_addr(e, mem_test_pkg::OFS_CTRL), ctrl);
        end
    endtask

    task automatic check_result(input int e, input logic [63:0] expected, input string what);
        logic [63:0] data;
        mmio_read(eng_addr(e, mem_test_pkg::OFS_CTRL), data);
        expect_value(data[1:0], 64'b01, {what, " status"});
        mmio_read(eng_addr(e, mem_test_pkg::OFS_SUM), data);
        expect_value(data, expected, {what, " checksum"});
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin : sequence_proc
        logic [63:0] data;
        logic [63:0] rnd;
        logic [63:0] seeds [mem_test_pkg::NUM_ENGINES];
        int counts [mem_test_pkg::NUM_ENGINES];
        int waited;
        mmio_req = '0;
        reset = 1'b1;
        cycle_count = 0;
        lfsr_state = 32'hadd7_f4da;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Identification and configuration readback
        mmio_read(mem_test_pkg::CSR_ID_LO, data);
        expect_value(data, mem_test_pkg::TEST_ID[63:0], "ID low");
        mmio_read(mem_test_pkg::CSR_ID_HI, data);
        expect_value(data, mem_test_pkg::TEST_ID[127:64], "ID high");
        mmio_read(mem_test_pkg::CSR_INFO, data);
        expect_value(data, 64'(mem_test_pkg::NUM_ENGINES), "engine count");
        for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
        begin
            random_bits(64, rnd);
            configure_engine(e, rnd[9:0], rnd[31:16], ~rnd);
            mmio_read(eng_addr(e, mem_test_pkg::OFS_BASE), data);
            expect_value(data, 64'(rnd[9:0]), "base readback");
            mmio_read(eng_addr(e, mem_test_pkg::OFS_COUNT), data);
            expect_value(data, 64'(rnd[31:16]), "count readback");
            mmio_read(eng_addr(e, mem_test_pkg::OFS_SEED), data);
            expect_value(data, ~rnd, "seed readback");
        end

        // One engine with a short run
        configure_engine(0, 10'd40, 16'd20, 64'h0123_4567_89ab_cdef);
        start_engine(0);
        wait_engine(0);
        check_result(0, ref_checksum(10'd40, 20, 64'h0123_4567_89ab_cdef), "single run");

        // All engines at once, each in its own quarter of memory
        for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
        begin
            random_bits(64, seeds[e]);
            random_bits(8, rnd);
            counts[e] = int'(rnd[7:0]) % 200 + 1;
            configure_engine(e, 10'(e * 256), 16'(counts[e]), seeds[e]);
        end
        for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
        begin
            start_engine(e);
        end
        for (int e = 0; e < mem_test_pkg::NUM_ENGINES; e++)
        begin
            wait_engine(e);
            check_result(e, ref_checksum(10'(e * 256), counts[e], seeds[e]), "parallel run");
        end

        // A second start waits in the queue behind a long run
        configure_engine(2, 10'd300, 16'd200, 64'hffff_ffff_ffff_ff00);
        start_engine(2);
        random_bits(64, seeds[2]);
        random_bits(8, rnd);
        counts[2] = int'(rnd[7:0]) % 200 + 1;
        mmio_write(eng_addr(2, mem_test_pkg::OFS_COUNT), 64'(counts[2]));
        mmio_write(eng_addr(2, mem_test_pkg::OFS_SEED), seeds[2]);
        start_engine(2);
        mmio_read(eng_addr(2, mem_test_pkg::OFS_CTRL), data);
        expect_value(64'(data[1]), 64'd1, "busy with queued start");
        wait_engine(2);
        check_result(2, ref_checksum(10'd300, counts[2], seeds[2]), "queued run");

        // Address wraps past the top of memory
        configure_engine(1, 10'd1015, 16'd30, 64'h8000_0000_0000_0001);
        start_engine(1);
        wait_engine(1);
        check_result(1, ref_checksum(10'd1015, 30, 64'h8000_0000_0000_0001), "wrapping run");

        // Empty run
        configure_engine(3, 10'd5, 16'd0, 64'h1111_2222_3333_4444);
        start_engine(3);
        wait_engine(3);
        check_result(3, 64'd0, "empty run");

        // Let the checker finish what is queued
        waited = 0;
        while (got_q.size() != 0)
        begin
            if (waited >= 100)
                abort_run("checker did not drain its queue within 100 cycles");
            else
            begin
                @(posedge clk);
                #1;
                waited++;
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
